//--- files.f
+incdir+dv
design/exerion_video_pkg.sv
design/video_timing.sv
design/char_layer.sv
design/layer_mixer.sv
design/exerion_video.sv
dv/exerion_video_properties.sv
dv/tb_exerion_video.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_exerion_video -f files.f

out=$(./obj_dir/Vtb_exerion_video) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
	exit 0
fi
exit 1

//--- dv/video_model.svh
/*
 * reference model of the video back end
 * shadow memories and control, mirror raster counter, pipeline history
 */
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

logic [7:0] m_vram [VRAM_DEPTH];
logic [7:0] m_char [CHAR_DEPTH];
rgb_t       m_pal  [PAL_DEPTH];
logic       m_flip;
logic       m_bank;
hcount_t    m_h;
vcount_t    m_v;
pal_idx_t   m_idx;       // index held by the mixer register
hcount_t    h_hist [$];  // newest first
vcount_t    v_hist [$];
pix_t       fg_hist [$];
logic [3:0] exp_raster;  // {h_blank, v_blank, h_sync, v_sync}
rgb_t       exp_rgb;

function automatic logic [3:0] raster_of(input hcount_t h, input vcount_t v);
	return {(h < H_BLANK_LO) || (h > H_BLANK_HI), (v < V_BLANK_LO) || (v > V_BLANK_HI),
		(h >= HSYNC_FIRST) && (h <= HSYNC_LAST), !((v >= VSYNC_FIRST) && (v <= VSYNC_LAST))};
endfunction

// foreground nibble for one count, from the tile and pattern rules
function automatic pix_t fg_of(input hcount_t h, input vcount_t v);
	hcount_t    fh;
	vcount_t    fv;
	logic [7:0] code;
	logic [7:0] pat;
	logic [1:0] pix;
	fh   = m_flip ? ~h : h;
	fv   = m_flip ? ~v : v;
	code = m_vram[{fv[7:3], fh[8:3]}];
	pat  = m_char[{m_bank, code[7:4], fv[2:0], code[3:0], fh[2]}];
	pix  = {pat[{1'b1, fh[1:0]}], pat[fh[1:0]]};
	return (pix == 2'b00) ? 4'h0 : {pix, code[7:6]};
endfunction

function automatic pal_idx_t idx_of(input logic blank, input pix_t fg, input pix_t sp,
		input pix_t bg);
	layer_e sel;
	if (blank)
		sel = LAYER_NONE;
	else if (fg != 4'h0)
		sel = LAYER_FG;
	else if (sp != 4'h0)
		sel = LAYER_SP;
	else if (bg != 4'h0)
		sel = LAYER_BG;
	else
		sel = LAYER_NONE;
	case (sel)
		LAYER_FG: return {1'b1, fg};
		LAYER_SP: return {1'b1, sp};
		LAYER_BG: return {1'b0, bg};  // lower half
		default:  return 5'd0;
	endcase
endfunction

task automatic model_reset();
	m_flip = 1'b0;
	m_bank = 1'b0;
	m_h    = H_START;
	m_v    = 8'd0;
	m_idx  = 5'd0;
	repeat (PIPE_LAT) begin
		h_hist.push_front(H_START);
		v_hist.push_front(8'd0);
		fg_hist.push_front(4'h0);
	end
endtask

// one rising edge, using the inputs that were applied to it
task automatic model_step();
	logic [3:0] rb;
	h_hist.push_front(m_h);
	v_hist.push_front(m_v);
	fg_hist.push_front(fg_of(m_h, m_v));
	void'(h_hist.pop_back());
	void'(v_hist.pop_back());
	void'(fg_hist.pop_back());
	exp_raster = raster_of(h_hist[PIPE_LAT-1], v_hist[PIPE_LAT-1]);
	exp_rgb    = m_pal[m_idx];  // palette before this edge's write
	rb         = raster_of(h_hist[CHAR_LAT], v_hist[CHAR_LAT]);
	m_idx      = idx_of(rb[3] | rb[2], fg_hist[CHAR_LAT], sp_pix_i, bg_pix_i);
	if (wr_i) begin
		case (wr_target_i)
			TGT_VRAM: m_vram[wr_addr_i[10:0]] = wr_data_i;
			TGT_CHAR: m_char[wr_addr_i] = wr_data_i;
			TGT_PAL:  m_pal[wr_addr_i[4:0]] = wr_data_i;
			default: begin
				m_flip = wr_data_i[CTRL_FLIP_BIT];
				m_bank = wr_data_i[CTRL_BANK_BIT];
			end
		endcase
	end
	if (m_h == H_LAST) begin
		m_h = H_START;
		m_v = m_v + 8'd1;
	end else begin
		m_h = m_h + 9'd1;
	end
endtask

`endif

//--- dv/tb_exerion_video.sv
/*
 * testbench for the video back end
 * random memory loads and layer stimulus checked against a cycle model
 */
`timescale 1ns/1ns

module tb_exerion_video;

	import exerion_video_pkg::*;

	localparam int FRAME_CYCLES = (int'(H_LAST) - int'(H_START) + 1) * 256;
	localparam int LOAD_WRITES  = PAL_DEPTH + CHAR_DEPTH + VRAM_DEPTH;
	localparam int CYCLE_LIMIT  = 5 * FRAME_CYCLES + LOAD_WRITES;

	logic       clk2_6MHZ;
	logic       RAMB;
	logic       wr_i;
	wr_target_e wr_target_i;
	wr_addr_t   wr_addr_i;
	logic [7:0] wr_data_i;
	pix_t       sp_pix_i;
	pix_t       bg_pix_i;
	rgb_t       rgb_o;
	logic       h_blank_o;
	logic       v_blank_o;
	logic       h_sync_o;
	logic       v_sync_o;

	integer     seed = 32'h23fd_7f98;
	int         errors = 0;
	int         cycles = 0;
	logic       rgb_live;  // memories loaded, colour is predictable

	`include "video_model.svh"

	exerion_video UUT (.*);

	always #2 clk2_6MHZ = ~clk2_6MHZ;

	// ==================================================
	// checks
	// ==================================================
	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	always @(posedge clk2_6MHZ) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	task automatic check_rgb(input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("** Error rgb_o: got %h, expected %h at %0t", got, exp, $time);
			errors++;
			abort_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
			errors++;
			abort_run();
		end
	endtask

	task automatic check_outputs(input logic [3:0] raster, input rgb_t rgb, input logic with_rgb);
		check_level("h_blank_o", h_blank_o, raster[3]);
		check_level("v_blank_o", v_blank_o, raster[2]);
		check_level("h_sync_o", h_sync_o, raster[1]);
		check_level("v_sync_o", v_sync_o, raster[0]);
		if (with_rgb)
			check_rgb(rgb_o, rgb);
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	task automatic tick();
		@(negedge clk2_6MHZ);
		model_step();
		check_outputs(exp_raster, exp_rgb, rgb_live);
	endtask

	// one strobe, only while the screen is in vertical blank
	task automatic cpu_write(input wr_target_e tgt, input wr_addr_t addr, input logic [7:0] data);
		while (!v_blank_o)
			tick();
		wr_i        = 1'b1;
		wr_target_i = tgt;
		wr_addr_i   = addr;
		wr_data_i   = data;
		tick();
		wr_i = 1'b0;
	endtask

	task automatic run_frame(input logic random_layers);
		repeat (FRAME_CYCLES) begin
			tick();
			sp_pix_i = random_layers ? 4'($random(seed)) : 4'h0;
			bg_pix_i = random_layers ? 4'($random(seed)) : 4'h0;
		end
	endtask

	initial begin
		clk2_6MHZ   = 1'b0;
		RAMB        = 1'b0;
		wr_i        = 1'b0;
		wr_target_i = TGT_VRAM;
		wr_addr_i   = '0;
		wr_data_i   = 8'h00;
		sp_pix_i    = 4'h0;
		bg_pix_i    = 4'h0;
		rgb_live    = 1'b0;
		model_reset();

		repeat (8) begin
			@(negedge clk2_6MHZ);
			check_outputs(4'b1101, 8'h00, 1'b1);  // blanks high, hsync low, vsync high
		end
		RAMB = 1'b1;

		for (int i = 0; i < PAL_DEPTH; i++)
			cpu_write(TGT_PAL, wr_addr_t'(i), 8'($random(seed)));
		for (int i = 0; i < CHAR_DEPTH; i++)
			cpu_write(TGT_CHAR, wr_addr_t'(i), 8'($random(seed)));
		for (int i = 0; i < VRAM_DEPTH; i++)
			cpu_write(TGT_VRAM, wr_addr_t'(i), 8'($random(seed)));
		rgb_live = 1'b1;

		run_frame(1'b0);                 // foreground alone
		run_frame(1'b1);                 // priority against sprite and background
		cpu_write(TGT_CTRL, '0, 8'h01);  // flip
		cpu_write(TGT_CTRL, '0, 8'h09);  // flip, upper pattern bank
		run_frame(1'b1);

		if (errors == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- dv/exerion_video_properties.sv
/*
 * raster and mixer properties, bound into the video top level
 */
`timescale 1ns/1ns

module exerion_video_properties (
	input logic                        clk2_6MHZ,
	input logic                        RAMB,
	input logic                        mix_blank_i,
	input exerion_video_pkg::pal_idx_t pal_idx_i,
	input logic                        h_blank_i,
	input logic                        v_blank_i,
	input logic                        h_sync_i,
	input logic                        v_sync_i
);

	// blanked pixels always read palette entry 0
	a_blank_idx: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		mix_blank_i |=> (pal_idx_i == 5'd0))
		else $error("palette index nonzero after a blanked pixel");

	a_vsync_in_vblank: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		!v_sync_i |-> v_blank_i)
		else $error("v_sync_o active outside vertical blank");

	a_hsync_in_hblank: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		h_sync_i |-> h_blank_i)
		else $error("h_sync_o active outside horizontal blank");

endmodule

bind exerion_video exerion_video_properties props (
	.clk2_6MHZ   (clk2_6MHZ),
	.RAMB        (RAMB),
	.mix_blank_i (mix_blank),
	.pal_idx_i   (u_mixer.pal_idx),
	.h_blank_i   (h_blank_o),
	.v_blank_i   (v_blank_o),
	.h_sync_i    (h_sync_o),
	.v_sync_i    (v_sync_o)
);

//--- design/exerion_video.sv
/*
 * exerion video back end
 * raster timing, foreground character layer and priority mixer
 */
`timescale 1ns/1ns

module exerion_video (
	input  logic                          clk2_6MHZ,
	input  logic                          RAMB,
	input  logic                          wr_i,
	input  exerion_video_pkg::wr_target_e wr_target_i,
	input  exerion_video_pkg::wr_addr_t   wr_addr_i,
	input  logic [7:0]                    wr_data_i,
	input  exerion_video_pkg::pix_t       sp_pix_i,
	input  exerion_video_pkg::pix_t       bg_pix_i,
	output exerion_video_pkg::rgb_t       rgb_o,
	output logic                          h_blank_o,
	output logic                          v_blank_o,
	output logic                          h_sync_o,
	output logic                          v_sync_o
);

	import exerion_video_pkg::*;

	hcount_t hcount;
	vcount_t vcount;
	logic    mix_blank;  // aligned with fg_pix
	pix_t    fg_pix;

	video_timing u_timing (
		.clk2_6MHZ   (clk2_6MHZ),
		.RAMB        (RAMB),
		.hcount_o    (hcount),
		.vcount_o    (vcount),
		.mix_blank_o (mix_blank),
		.h_blank_o   (h_blank_o),
		.v_blank_o   (v_blank_o),
		.h_sync_o    (h_sync_o),
		.v_sync_o    (v_sync_o)
	);

	char_layer u_char (
		.clk2_6MHZ   (clk2_6MHZ),
		.RAMB        (RAMB),
		.wr_i        (wr_i),
		.wr_target_i (wr_target_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.hcount_i    (hcount),
		.vcount_i    (vcount),
		.fg_pix_o    (fg_pix)
	);

	// sprite and background nibbles enter here
	layer_mixer u_mixer (
		.clk2_6MHZ   (clk2_6MHZ),
		.RAMB        (RAMB),
		.wr_i        (wr_i),
		.wr_target_i (wr_target_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.mix_blank_i (mix_blank),
		.fg_pix_i    (fg_pix),
		.sp_pix_i    (sp_pix_i),
		.bg_pix_i    (bg_pix_i),
		.rgb_o       (rgb_o)
	);

endmodule

//--- design/layer_mixer.sv
/*
 * layer priority mixer
 * foreground over sprites over background, then palette lookup to 8-bit RGB
 */
`timescale 1ns/1ns

module layer_mixer (
	input  logic                          clk2_6MHZ,
	input  logic                          RAMB,
	input  logic                          wr_i,
	input  exerion_video_pkg::wr_target_e wr_target_i,
	input  exerion_video_pkg::wr_addr_t   wr_addr_i,
	input  logic [7:0]                    wr_data_i,
	input  logic                          mix_blank_i,
	input  exerion_video_pkg::pix_t       fg_pix_i,
	input  exerion_video_pkg::pix_t       sp_pix_i,
	input  exerion_video_pkg::pix_t       bg_pix_i,
	output exerion_video_pkg::rgb_t       rgb_o
);

	import exerion_video_pkg::*;

	layer_e   layer_sel;
	pal_idx_t idx_next;
	pal_idx_t pal_idx;   // registered palette address

	rgb_t     pal [PAL_DEPTH];

	// ==================================================
	// priority select
	// ==================================================
	always_comb begin
		if (mix_blank_i)
			layer_sel = LAYER_NONE;
		else if (fg_pix_i != '0)
			layer_sel = LAYER_FG;
		else if (sp_pix_i != '0)
			layer_sel = LAYER_SP;
		else if (bg_pix_i != '0)
			layer_sel = LAYER_BG;
		else
			layer_sel = LAYER_NONE;
	end

	// background uses the darker lower half of the palette
	always_comb begin
		case (layer_sel)
			LAYER_FG: idx_next = {1'b1, fg_pix_i};
			LAYER_SP: idx_next = {1'b1, sp_pix_i};
			LAYER_BG: idx_next = {1'b0, bg_pix_i};
			default:  idx_next = '0;
		endcase
	end

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB)
			pal_idx <= '0;
		else
			pal_idx <= idx_next;
	end

	// ==================================================
	// palette
	// ==================================================
	always_ff @(posedge clk2_6MHZ) begin
		if (wr_i && wr_target_i == TGT_PAL)
			pal[wr_addr_i[4:0]] <= wr_data_i;
	end

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB)
			rgb_o <= '0;
		else
			rgb_o <= pal[pal_idx];  // {blue, green, red}
	end

endmodule

//--- design/char_layer.sv
/*
 * foreground character layer
 * tile RAM and pattern memory lookup, 2bpp decode into a colour nibble
 */
`timescale 1ns/1ns

module char_layer (
	input  logic                          clk2_6MHZ,
	input  logic                          RAMB,
	input  logic                          wr_i,
	input  exerion_video_pkg::wr_target_e wr_target_i,
	input  exerion_video_pkg::wr_addr_t   wr_addr_i,
	input  logic [7:0]                    wr_data_i,
	input  exerion_video_pkg::hcount_t    hcount_i,
	input  exerion_video_pkg::vcount_t    vcount_i,
	output exerion_video_pkg::pix_t       fg_pix_o
);

	import exerion_video_pkg::*;

	// control latch
	logic flip;
	logic bank;   // pattern memory a12

	hcount_t fh;  // count after flip
	vcount_t fv;

	logic [7:0]  vram [VRAM_DEPTH];
	logic [7:0]  char_mem [CHAR_DEPTH];

	logic [10:0] tile_addr;
	logic [12:0] pat_addr;

	// stage 1
	logic [7:0]  tile_code;
	logic [2:0]  line_s1;
	logic [2:0]  col_s1;

	// stage 2
	logic [7:0]  pat_byte;
	logic [1:0]  k_s2;
	logic [1:0]  tc_hi_s2;

	logic [1:0]  pix2;

	// ==================================================
	// control latch and cpu writes
	// ==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			flip <= 1'b0;
			bank <= 1'b0;
		end else if (wr_i && wr_target_i == TGT_CTRL) begin
			flip <= wr_data_i[CTRL_FLIP_BIT];  // screen inversion for player 2
			bank <= wr_data_i[CTRL_BANK_BIT];
		end
	end

	always_ff @(posedge clk2_6MHZ) begin
		if (wr_i && wr_target_i == TGT_VRAM)
			vram[wr_addr_i[10:0]] <= wr_data_i;
	end

	always_ff @(posedge clk2_6MHZ) begin
		if (wr_i && wr_target_i == TGT_CHAR)
			char_mem[wr_addr_i] <= wr_data_i;
	end

	// ==================================================
	// pixel pipeline
	// ==================================================
	assign fh = flip ? ~hcount_i : hcount_i;
	assign fv = flip ? ~vcount_i : vcount_i;

	// 32 rows of 64 tiles
	assign tile_addr = {fv[7:3], fh[8:3]};

	// first cycle reads the tile code
	always_ff @(posedge clk2_6MHZ) begin
		tile_code <= vram[tile_addr];
		line_s1   <= fv[2:0];
		col_s1    <= fh[2:0];
	end

	// each pattern byte covers 4 pixels of one tile row
	assign pat_addr = {bank, tile_code[7:4], line_s1, tile_code[3:0], col_s1[2]};

	// second cycle reads the pattern byte
	always_ff @(posedge clk2_6MHZ) begin
		pat_byte <= char_mem[pat_addr];
		k_s2     <= col_s1[1:0];
		tc_hi_s2 <= tile_code[7:6];
	end

	// plane 1 in the high nibble, plane 0 in the low nibble
	always_comb begin
		case (k_s2)
			2'd0:    pix2 = {pat_byte[4], pat_byte[0]};
			2'd1:    pix2 = {pat_byte[5], pat_byte[1]};
			2'd2:    pix2 = {pat_byte[6], pat_byte[2]};
			default: pix2 = {pat_byte[7], pat_byte[3]};
		endcase
	end

	// colour from the tile code top bits, pixel 0 stays transparent
	assign fg_pix_o = (pix2 == 2'b00) ? '0 : {pix2, tc_hi_s2};

endmodule

//--- design/video_timing.sv
/*
 * video timing
 * raster counters, blank and sync decode, delay lines to line up with the pixel pipeline
 */
`timescale 1ns/1ns

module video_timing (
	input  logic                       clk2_6MHZ,
	input  logic                       RAMB,
	output exerion_video_pkg::hcount_t hcount_o,
	output exerion_video_pkg::vcount_t vcount_o,
	output logic                       mix_blank_o,
	output logic                       h_blank_o,
	output logic                       v_blank_o,
	output logic                       h_sync_o,
	output logic                       v_sync_o
);

	import exerion_video_pkg::*;

	hcount_t h_cnt;
	vcount_t v_cnt;

	logic h_blank;
	logic v_blank;
	logic h_sync;
	logic v_sync;

	logic [CHAR_LAT-1:0] mb_sr;   // feeds the mixer
	logic [PIPE_LAT-1:0] hb_sr;
	logic [PIPE_LAT-1:0] vb_sr;
	logic [PIPE_LAT-1:0] hs_sr;
	logic [PIPE_LAT-1:0] vs_sr;

	// ==================================================
	// raster counters
	// ==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			h_cnt <= H_START;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= H_START;
			v_cnt <= v_cnt + 8'd1;  // 255 rolls over to 0
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	assign hcount_o = h_cnt;
	assign vcount_o = v_cnt;

	// decode from the live count
	assign h_blank = (h_cnt < H_BLANK_LO) || (h_cnt > H_BLANK_HI);
	assign v_blank = (v_cnt < V_BLANK_LO) || (v_cnt > V_BLANK_HI);
	assign h_sync  = (h_cnt >= HSYNC_FIRST) && (h_cnt <= HSYNC_LAST);
	assign v_sync  = !((v_cnt >= VSYNC_FIRST) && (v_cnt <= VSYNC_LAST));

	// ==================================================
	// delay lines
	// ==================================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			mb_sr <= '1;  // idle levels
			hb_sr <= '1;
			vb_sr <= '1;
			hs_sr <= '0;
			vs_sr <= '1;
		end else begin
			mb_sr <= {mb_sr[CHAR_LAT-2:0], h_blank | v_blank};
			hb_sr <= {hb_sr[PIPE_LAT-2:0], h_blank};
			vb_sr <= {vb_sr[PIPE_LAT-2:0], v_blank};
			hs_sr <= {hs_sr[PIPE_LAT-2:0], h_sync};
			vs_sr <= {vs_sr[PIPE_LAT-2:0], v_sync};
		end
	end

	assign mix_blank_o = mb_sr[CHAR_LAT-1];
	assign h_blank_o   = hb_sr[PIPE_LAT-1];
	assign v_blank_o   = vb_sr[PIPE_LAT-1];
	assign h_sync_o    = hs_sr[PIPE_LAT-1];
	assign v_sync_o    = vs_sr[PIPE_LAT-1];

endmodule

//--- design/exerion_video_pkg.sv
/*
 * exerion video package
 * raster constants, field widths, shared types and enums for the video back end
 */

package exerion_video_pkg;

	// ==================================================
	// field widths
	// ==================================================
	localparam int H_W       = 9;
	localparam int V_W       = 8;
	localparam int PIX_W     = 4;
	localparam int PAL_IDX_W = 5;
	localparam int RGB_W     = 8;
	localparam int WR_ADDR_W = 13;

	typedef logic [H_W-1:0]       hcount_t;
	typedef logic [V_W-1:0]       vcount_t;
	typedef logic [PIX_W-1:0]     pix_t;      // 0 is transparent
	typedef logic [PAL_IDX_W-1:0] pal_idx_t;
	typedef logic [RGB_W-1:0]     rgb_t;      // {blue[1:0], green[2:0], red[2:0]}
	typedef logic [WR_ADDR_W-1:0] wr_addr_t;

	// cpu side write targets
	typedef enum logic [1:0] {
		TGT_VRAM = 2'd0,
		TGT_CHAR = 2'd1,
		TGT_PAL  = 2'd2,
		TGT_CTRL = 2'd3
	} wr_target_e;

	// layer picked by the priority mixer
	typedef enum logic [1:0] {
		LAYER_NONE = 2'd0,
		LAYER_FG   = 2'd1,
		LAYER_SP   = 2'd2,
		LAYER_BG   = 2'd3
	} layer_e;

	// ==================================================
	// raster
	// ==================================================
	localparam hcount_t H_START     = 9'd88;
	localparam hcount_t H_LAST      = 9'd511;
	localparam hcount_t H_BLANK_LO  = 9'd107;  // blank below this
	localparam hcount_t H_BLANK_HI  = 9'd428;  // and above this
	localparam hcount_t HSYNC_FIRST = 9'd464;
	localparam hcount_t HSYNC_LAST  = 9'd479;

	localparam vcount_t V_BLANK_LO  = 8'd16;
	localparam vcount_t V_BLANK_HI  = 8'd239;
	localparam vcount_t VSYNC_FIRST = 8'd248;  // v_sync is active low
	localparam vcount_t VSYNC_LAST  = 8'd251;

	// pipeline depths counted from the registered count
	localparam int CHAR_LAT = 2;
	localparam int PIPE_LAT = 4;

	// control latch bit positions
	localparam int CTRL_FLIP_BIT = 0;
	localparam int CTRL_BANK_BIT = 3;

	// memory sizes
	localparam int VRAM_DEPTH = 2048;
	localparam int CHAR_DEPTH = 8192;
	localparam int PAL_DEPTH  = 32;

endpackage
